//--- Bender.yml
package:
  name: lite_write_mux

sources:
  - files:
      - hdl/lite_mux_cfg_pkg.sv
      - hdl/axi_lite_chan_pkg.sv
      - hdl/lite_rr_arbiter.sv
      - hdl/route_fifo.sv
      - hdl/lite_aw_stage.sv
      - hdl/lite_wb_router.sv
      - hdl/lite_write_mux.sv
  - target: test
    files:
      - bench/lite_write_mux_assert.sv
      - bench/tb_lite_write_mux.sv

//--- bench/lite_write_mux_assert.sv
`timescale 1ns/1ns
`default_nettype none

module lite_write_mux_assert import lite_mux_cfg_pkg::*, axi_lite_chan_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      mst_aw_valid_o,
  input logic      mst_aw_ready_i,
  input addr_t     mst_aw_addr_o,
  input prot_t     mst_aw_prot_o,
  input logic      mst_w_valid_o,
  input logic      mst_w_ready_i,
  input data_t     mst_w_data_o,
  input strb_t     mst_w_strb_o,
  input logic      mst_b_valid_i,
  input port_vec_t slv_b_valid_o
);

  // Failures seen, read by the testbench
  int fail_cnt = 0;

  // AW payload frozen during a stall
  aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_aw_valid_o && !mst_aw_ready_i |=>
      mst_aw_valid_o && $stable(mst_aw_addr_o) && $stable(mst_aw_prot_o))
    else begin
      $error("AW valid or payload changed while stalled");
      fail_cnt++;
    end

  // Same for W
  w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_w_valid_o && !mst_w_ready_i |=>
      mst_w_valid_o && $stable(mst_w_data_o) && $stable(mst_w_strb_o))
    else begin
      $error("W valid or payload changed while stalled");
      fail_cnt++;
    end

  // Port B valid only with a completer response
  b_source: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    |slv_b_valid_o |-> mst_b_valid_i)
    else begin
      $error("Port B valid without completer B valid");
      fail_cnt++;
    end

  b_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(slv_b_valid_o))
    else begin
      $error("B valid raised on more than one port");
      fail_cnt++;
    end

endmodule

bind lite_write_mux lite_write_mux_assert i_assert (.*);

`default_nettype wire

//--- bench/tb_lite_write_mux.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lite_write_mux import lite_mux_cfg_pkg::*, axi_lite_chan_pkg::*;;

  localparam int MAX_WR  = 16;
  // 4 single + 12 all-port + 8 AW-stall + 6 W-hold writes
  localparam int PLAN_WR = 30;

  logic                  clk_i          = 1'b0;
  logic                  arst_n_i       = 1'b0;
  port_vec_t             slv_aw_valid_i = '0;
  addr_t [NUM_PORTS-1:0] slv_aw_addr_i  = '0;
  prot_t [NUM_PORTS-1:0] slv_aw_prot_i  = '0;
  port_vec_t             slv_w_valid_i  = '0;
  data_t [NUM_PORTS-1:0] slv_w_data_i   = '0;
  strb_t [NUM_PORTS-1:0] slv_w_strb_i   = '0;
  port_vec_t             slv_b_ready_i  = '0;
  logic                  mst_aw_ready_i = 1'b0;
  logic                  mst_w_ready_i  = 1'b0;
  logic                  mst_b_valid_i  = 1'b0;
  resp_e                 mst_b_resp_i   = RESP_OKAY;
  port_vec_t             slv_aw_ready_o, slv_w_ready_o, slv_b_valid_o;
  resp_e [NUM_PORTS-1:0] slv_b_resp_o;
  logic                  mst_aw_valid_o, mst_w_valid_o, mst_b_ready_o;
  addr_t                 mst_aw_addr_o;
  prot_t                 mst_aw_prot_o;
  data_t                 mst_w_data_o;
  strb_t                 mst_w_strb_o;

  integer seed = 32'h352c2b52;
  int     err_cnt;
  string  test_name;
  // Per-port write tables, filled at falling edges
  addr_t  addr_tab [NUM_PORTS][MAX_WR];
  data_t  data_tab [NUM_PORTS][MAX_WR];
  strb_t  strb_tab [NUM_PORTS][MAX_WR];
  prot_t  prot_tab [NUM_PORTS][MAX_WR];
  int     n_load [NUM_PORTS];
  int     aw_i [NUM_PORTS];
  int     w_i [NUM_PORTS];
  int     aw_seen [NUM_PORTS];
  int     w_seen [NUM_PORTS];
  int     n_total, aw_total, b_done, aw_base, rr_ptr;
  bit     decided, aw_stall, w_rand, w_hold;
  port_sel_t exp_sel;
  // Expected W order, then expected B order
  port_sel_t w_order [$];
  port_sel_t b_port [$];
  resp_e     b_code [$];

  lite_write_mux DUT (.*);

  always #2 clk_i = ~clk_i;

  // --------------------------------------------------
  // Reference and compare helpers
  // --------------------------------------------------
  // First requester at or after the pointer
  function automatic port_sel_t rr_ref(input port_vec_t mask, input int ptr);
    int idx;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = (ptr + k) % NUM_PORTS;
      if (mask[idx]) return port_sel_t'(idx);
    end
    return port_sel_t'(ptr);
  endfunction

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input string what, input resp_e exp, input resp_e act);
    if (exp !== act) begin
      $display("** Error %s %s: expected %s, actual %s", test_name, what, exp.name(),
               act.name());
      err_cnt++;
    end
  endtask

  task automatic check_port(input string what, input port_sel_t exp, input port_sel_t act);
    if (exp !== act) begin
      $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  // New write for port p, address tagged with port and sequence
  task automatic load_write(input int p);
    int          n;
    logic [31:0] rnd;
    n   = n_load[p];
    rnd = $random(seed);
    addr_tab[p][n] = {8'(p), 16'(n_total), 8'h00};
    data_tab[p][n] = rnd;
    strb_tab[p][n] = rnd[11:8];
    prot_tab[p][n] = rnd[14:12];
    n_load[p] = n + 1;
    n_total++;
  endtask

  task automatic wait_done();
    while (b_done != n_total) @(negedge clk_i);
  endtask

  // --------------------------------------------------
  // Requester ports
  // --------------------------------------------------
  always @(posedge clk_i) begin : req_drive
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (slv_aw_valid_i[p] && slv_aw_ready_o[p]) aw_i[p]++;
      if (slv_w_valid_i[p] && slv_w_ready_o[p]) w_i[p]++;
      // W offered early, the mux must hold it back
      slv_aw_valid_i[p] <= (aw_i[p] < n_load[p]);
      slv_aw_addr_i[p]  <= addr_tab[p][aw_i[p]];
      slv_aw_prot_i[p]  <= prot_tab[p][aw_i[p]];
      slv_w_valid_i[p]  <= (w_i[p] < n_load[p]);
      slv_w_data_i[p]   <= data_tab[p][w_i[p]];
      slv_w_strb_i[p]   <= strb_tab[p][w_i[p]];
    end
  end

  // --------------------------------------------------
  // Completer model and checks
  // --------------------------------------------------
  always @(posedge clk_i) begin : completer
    port_sel_t   p;
    port_sel_t   got;
    int          hits;
    logic [31:0] rnd;
    got  = '0;
    hits = 0;
    rnd  = $random(seed);
    // Arbiter decides once a request shows up
    if (!decided && |slv_aw_valid_i) begin
      exp_sel = rr_ref(slv_aw_valid_i, rr_ptr);
      decided = 1'b1;
      w_order.push_back(exp_sel);
    end
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      check_addr("aw addr", addr_tab[exp_sel][aw_seen[exp_sel]], mst_aw_addr_o);
      check_data("aw prot", data_t'(prot_tab[exp_sel][aw_seen[exp_sel]]),
                 data_t'(mst_aw_prot_o));
      aw_seen[exp_sel]++;
      aw_total++;
      rr_ptr  = (int'(exp_sel) + 1) % NUM_PORTS;
      decided = 1'b0;
    end
    if (mst_w_valid_o && mst_w_ready_i) begin
      if (w_order.size() == 0) begin
        $display("W beat forwarded with no address granted before it");
        err_cnt++;
      end else begin
        p = w_order.pop_front();
        check_data("w data", data_tab[p][w_seen[p]], mst_w_data_o);
        check_data("w strb", data_t'(strb_tab[p][w_seen[p]]), data_t'(mst_w_strb_o));
        b_port.push_back(p);
        b_code.push_back(resp_e'(data_tab[p][w_seen[p]] % 4));
        w_seen[p]++;
      end
    end
    // Completer B ready follows the ready of the expected port
    if (mst_b_valid_i && b_port.size() > 0) begin
      if (mst_b_ready_o !== slv_b_ready_i[b_port[0]]) begin
        $display("Completer B ready does not follow the B ready of port %0d", b_port[0]);
        err_cnt++;
      end
    end
    if (mst_b_valid_i && mst_b_ready_o) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (slv_b_valid_o[q]) begin
          hits++;
          got = port_sel_t'(q);
        end
      end
      if (hits != 1) begin
        $display("B response reached %0d ports instead of one", hits);
        err_cnt++;
      end
      check_port("b port", b_port[0], got);
      check_resp("b resp", b_code[0], slv_b_resp_o[got]);
      void'(b_port.pop_front());
      void'(b_code.pop_front());
      b_done++;
    end
    // Head of the B queue stays put until taken
    mst_b_valid_i  <= (b_code.size() > 0);
    mst_b_resp_i   <= (b_code.size() > 0) ? b_code[0] : RESP_OKAY;
    mst_aw_ready_i <= aw_stall ? (rnd[1:0] == 2'b00) : 1'b1;
    mst_w_ready_i  <= w_hold ? 1'b0 : (w_rand ? rnd[2] : 1'b1);
    slv_b_ready_i  <= aw_stall ? rnd[7:4] : '1;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main
    test_name = "single";
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      @(negedge clk_i);
      load_write(p);
      wait_done();
    end
    // Every port keeps requesting for three rounds
    test_name = "all_ports";
    @(negedge clk_i);
    for (int r = 0; r < 3; r++) begin
      for (int p = 0; p < NUM_PORTS; p++) load_write(p);
    end
    wait_done();
    test_name = "aw_stall";
    @(negedge clk_i);
    aw_stall = 1'b1;
    w_rand   = 1'b1;
    for (int k = 0; k < 2 * NUM_PORTS; k++) load_write(k % NUM_PORTS);
    wait_done();
    aw_stall = 1'b0;
    w_rand   = 1'b0;
    // W held off, AW stops once the routing FIFO fills
    test_name = "w_hold";
    @(negedge clk_i);
    w_hold  = 1'b1;
    aw_base = aw_total;
    for (int k = 0; k < 6; k++) load_write(k % NUM_PORTS);
    repeat (40) @(negedge clk_i);
    check_data("aw before stall", data_t'(ROUTE_DEPTH), data_t'(aw_total - aw_base));
    w_hold = 1'b0;
    wait_done();
    check_data("aw total", data_t'(n_total), data_t'(aw_total));
    $display("Check errors: %0d, assertion errors: %0d", err_cnt, DUT.i_assert.fail_cnt);
    if (err_cnt == 0 && DUT.i_assert.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // 200 cycles for each planned write
  initial begin : watchdog
    repeat (200 * PLAN_WR + 5) @(posedge clk_i);
    $display("Timeout: writes still outstanding after %0d cycles", 200 * PLAN_WR);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/lite_mux_cfg_pkg.sv
hdl/axi_lite_chan_pkg.sv
hdl/lite_rr_arbiter.sv
hdl/route_fifo.sv
hdl/lite_aw_stage.sv
hdl/lite_wb_router.sv
hdl/lite_write_mux.sv
bench/lite_write_mux_assert.sv
bench/tb_lite_write_mux.sv

//--- hdl/axi_lite_chan_pkg.sv
`default_nettype none

package axi_lite_chan_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // --------------------------------------------------
  // Channel fields
  // --------------------------------------------------

  // AW address
  typedef logic [ADDR_W-1:0] addr_t;

  // W payload and one strobe per byte lane
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;

  // AW protection attributes
  typedef logic [2:0] prot_t;

  // B response code, encoding as on the bus
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

//--- hdl/lite_aw_stage.sv
`timescale 1ns/1ns
`default_nettype none

module lite_aw_stage import lite_mux_cfg_pkg::*, axi_lite_chan_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  port_vec_t             slv_aw_valid_i,
  input  addr_t [NUM_PORTS-1:0] slv_aw_addr_i,
  input  prot_t [NUM_PORTS-1:0] slv_aw_prot_i,
  output port_vec_t             slv_aw_ready_o,
  output logic                  mst_aw_valid_o,
  output addr_t                 mst_aw_addr_o,
  output prot_t                 mst_aw_prot_o,
  input  logic                  mst_aw_ready_i,
  input  logic                  route_full_i,
  output logic                  route_push_o,
  output port_sel_t             route_sel_o
);

  // Locked once the index is queued but AW still waits
  typedef enum logic {
    AW_FREE,
    AW_LOCKED
  } aw_lock_e;

  aw_lock_e aw_state_q;
  aw_lock_e aw_state_d;
  logic     req_valid;
  logic     grant_ready;

  lite_rr_arbiter i_aw_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_aw_valid_i ),
    .addr_i   ( slv_aw_addr_i  ),
    .prot_i   ( slv_aw_prot_i  ),
    .gnt_o    ( slv_aw_ready_o ),
    .ready_i  ( grant_ready    ),
    .valid_o  ( req_valid      ),
    .addr_o   ( mst_aw_addr_o  ),
    .prot_o   ( mst_aw_prot_o  ),
    .sel_o    ( route_sel_o    )
  );

  // --------------------------------------------------
  // AW handshake and routing push
  // --------------------------------------------------
  always_comb begin
    aw_state_d     = aw_state_q;
    mst_aw_valid_o = 1'b0;
    route_push_o   = 1'b0;
    grant_ready    = 1'b0;
    if (aw_state_q == AW_LOCKED) begin
      // Index already queued, just finish the transfer
      mst_aw_valid_o = 1'b1;
      if (mst_aw_ready_i) begin
        grant_ready = 1'b1;
        aw_state_d  = AW_FREE;
      end
    end else if (req_valid && !route_full_i) begin
      mst_aw_valid_o = 1'b1;
      route_push_o   = 1'b1;
      if (mst_aw_ready_i) begin
        grant_ready = 1'b1;
      end else begin
        aw_state_d = AW_LOCKED;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_state_q <= AW_FREE;
    end else begin
      aw_state_q <= aw_state_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/lite_mux_cfg_pkg.sv
`default_nettype none

package lite_mux_cfg_pkg;

  // --------------------------------------------------
  // Multiplexer sizing
  // --------------------------------------------------

  // Requester ports sharing the one completer port
  localparam int NUM_PORTS = 4;

  // Outstanding writes per routing FIFO
  localparam int ROUTE_DEPTH = 4;

  // Bits needed to name one requester port
  localparam int PORT_SEL_W = 2;

  // --------------------------------------------------
  // Port-select types
  // --------------------------------------------------

  // Index of one requester port
  typedef logic [PORT_SEL_W-1:0] port_sel_t;

  // One flag per requester port
  typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

`default_nettype wire

//--- hdl/lite_rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module lite_rr_arbiter import lite_mux_cfg_pkg::*, axi_lite_chan_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  port_vec_t             req_i,
  input  addr_t [NUM_PORTS-1:0] addr_i,
  input  prot_t [NUM_PORTS-1:0] prot_i,
  output port_vec_t             gnt_o,
  input  logic                  ready_i,
  output logic                  valid_o,
  output addr_t                 addr_o,
  output prot_t                 prot_o,
  output port_sel_t             sel_o
);

  // Round-robin start point
  port_sel_t ptr_q;
  // Held decision while a grant waits for ready
  logic      lock_q;
  port_sel_t lock_sel_q;
  // Fresh decision from the pointer
  port_sel_t rr_sel;
  logic      rr_found;

  // First request at or after the pointer
  always_comb begin : p_rr_pick
    int idx;
    rr_sel   = ptr_q;
    rr_found = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = (int'(ptr_q) + k) % NUM_PORTS;
      if (!rr_found && req_i[idx]) begin
        rr_sel   = port_sel_t'(idx);
        rr_found = 1'b1;
      end
    end
  end

  // Locked choice wins over a fresh pick
  assign sel_o   = lock_q ? lock_sel_q : rr_sel;
  assign valid_o = lock_q ? req_i[lock_sel_q] : rr_found;
  assign addr_o  = addr_i[sel_o];
  assign prot_o  = prot_i[sel_o];

  // Grant only to the selected port, on transfer
  always_comb begin
    gnt_o        = '0;
    gnt_o[sel_o] = valid_o & ready_i;
  end

  // Pointer advance and lock-in
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else if (valid_o) begin
      if (ready_i) begin
        // Transfer done, next search starts past the winner
        lock_q <= 1'b0;
        ptr_q  <= (int'(sel_o) == NUM_PORTS - 1) ? '0 : sel_o + 1'b1;
      end else begin
        lock_q     <= 1'b1;
        lock_sel_q <= sel_o;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/lite_wb_router.sv
`timescale 1ns/1ns
`default_nettype none

module lite_wb_router import lite_mux_cfg_pkg::*, axi_lite_chan_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  port_sel_t             wsel_i,
  input  logic                  wsel_empty_i,
  output logic                  wsel_pop_o,
  input  port_vec_t             slv_w_valid_i,
  input  data_t [NUM_PORTS-1:0] slv_w_data_i,
  input  strb_t [NUM_PORTS-1:0] slv_w_strb_i,
  output port_vec_t             slv_w_ready_o,
  output logic                  mst_w_valid_o,
  output data_t                 mst_w_data_o,
  output strb_t                 mst_w_strb_o,
  input  logic                  mst_w_ready_i,
  input  logic                  mst_b_valid_i,
  input  resp_e                 mst_b_resp_i,
  output logic                  mst_b_ready_o,
  output port_vec_t             slv_b_valid_o,
  output resp_e [NUM_PORTS-1:0] slv_b_resp_o,
  input  port_vec_t             slv_b_ready_i
);

  port_sel_t bsel;
  logic      b_full;
  logic      b_empty;
  logic      b_pop;
  logic      w_open;

  // --------------------------------------------------
  // W channel
  // --------------------------------------------------
  // Need a queued AW and room to remember the B route
  assign w_open        = ~wsel_empty_i & ~b_full;
  assign mst_w_valid_o = w_open & slv_w_valid_i[wsel_i];
  assign mst_w_data_o  = slv_w_data_i[wsel_i];
  assign mst_w_strb_o  = slv_w_strb_i[wsel_i];
  assign wsel_pop_o    = mst_w_valid_o & mst_w_ready_i;

  // --------------------------------------------------
  // B channel
  // --------------------------------------------------
  // Response goes back to the head port only
  assign mst_b_ready_o = ~b_empty & slv_b_ready_i[bsel];
  assign b_pop         = mst_b_valid_i & mst_b_ready_o;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign slv_w_ready_o[i] = mst_w_ready_i & w_open & (wsel_i == port_sel_t'(i));
    assign slv_b_valid_o[i] = mst_b_valid_i & ~b_empty & (bsel == port_sel_t'(i));
    // Code fans out, valid picks the port
    assign slv_b_resp_o[i]  = mst_b_resp_i;
  end

  // Route for each forwarded W beat
  route_fifo i_b_route (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .push_i   ( wsel_pop_o ),
    .data_i   ( wsel_i     ),
    .pop_i    ( b_pop      ),
    .data_o   ( bsel       ),
    .full_o   ( b_full     ),
    .empty_o  ( b_empty    )
  );

endmodule

`default_nettype wire

//--- hdl/lite_write_mux.sv
`timescale 1ns/1ns
`default_nettype none

module lite_write_mux import lite_mux_cfg_pkg::*, axi_lite_chan_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Requester ports
  input  port_vec_t             slv_aw_valid_i,
  input  addr_t [NUM_PORTS-1:0] slv_aw_addr_i,
  input  prot_t [NUM_PORTS-1:0] slv_aw_prot_i,
  output port_vec_t             slv_aw_ready_o,
  input  port_vec_t             slv_w_valid_i,
  input  data_t [NUM_PORTS-1:0] slv_w_data_i,
  input  strb_t [NUM_PORTS-1:0] slv_w_strb_i,
  output port_vec_t             slv_w_ready_o,
  output port_vec_t             slv_b_valid_o,
  output resp_e [NUM_PORTS-1:0] slv_b_resp_o,
  input  port_vec_t             slv_b_ready_i,
  // Completer port
  output logic                  mst_aw_valid_o,
  output addr_t                 mst_aw_addr_o,
  output prot_t                 mst_aw_prot_o,
  input  logic                  mst_aw_ready_i,
  output logic                  mst_w_valid_o,
  output data_t                 mst_w_data_o,
  output strb_t                 mst_w_strb_o,
  input  logic                  mst_w_ready_i,
  input  logic                  mst_b_valid_i,
  input  resp_e                 mst_b_resp_i,
  output logic                  mst_b_ready_o
);

  // AW order, consumed by W
  logic      wr_push;
  port_sel_t wr_sel;
  logic      wr_full;
  port_sel_t wsel;
  logic      wsel_empty;
  logic      wsel_pop;

  lite_aw_stage i_aw_stage (
    .clk_i, .arst_n_i,
    .slv_aw_valid_i, .slv_aw_addr_i, .slv_aw_prot_i, .slv_aw_ready_o,
    .mst_aw_valid_o, .mst_aw_addr_o, .mst_aw_prot_o, .mst_aw_ready_i,
    .route_full_i ( wr_full ),
    .route_push_o ( wr_push ),
    .route_sel_o  ( wr_sel  )
  );

  route_fifo i_w_route (
    .clk_i, .arst_n_i,
    .push_i  ( wr_push    ),
    .data_i  ( wr_sel     ),
    .pop_i   ( wsel_pop   ),
    .data_o  ( wsel       ),
    .full_o  ( wr_full    ),
    .empty_o ( wsel_empty )
  );

  lite_wb_router i_wb_router (
    .clk_i, .arst_n_i,
    .wsel_i       ( wsel       ),
    .wsel_empty_i ( wsel_empty ),
    .wsel_pop_o   ( wsel_pop   ),
    .slv_w_valid_i, .slv_w_data_i, .slv_w_strb_i, .slv_w_ready_o,
    .mst_w_valid_o, .mst_w_data_o, .mst_w_strb_o, .mst_w_ready_i,
    .mst_b_valid_i, .mst_b_resp_i, .mst_b_ready_o,
    .slv_b_valid_o, .slv_b_resp_o, .slv_b_ready_i
  );

endmodule

`default_nettype wire

//--- hdl/route_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module route_fifo import lite_mux_cfg_pkg::*; #(
  parameter int DEPTH = ROUTE_DEPTH
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      push_i,
  input  port_sel_t data_i,
  input  logic      pop_i,
  output port_sel_t data_o,
  output logic      full_o,
  output logic      empty_o
);

  // Storage, payload only
  port_sel_t                     mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]      wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]      rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]    cnt_q;
  logic                          push_ok;
  logic                          pop_ok;

  assign full_o  = (int'(cnt_q) == DEPTH);
  assign empty_o = (cnt_q == '0);

  // Drop pushes when full and pops when empty
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  // Head entry, valid only when not empty
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at DEPTH, any depth allowed
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count moves only when one side acts alone
      if (push_ok && !pop_ok) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
